// ==== design/cpu_pkg.sv ====
/*
 * Shared definitions for the MIPS-subset core.
 * Holds queue sizing, the reset PC, instruction encodings and the
 * structs passed between fetch, queue and execute.
 */

package cpu_pkg;

    localparam int QUEUE_DEPTH = 4;                      // also the initial fetch credit
    localparam int CREDIT_W    = $clog2(QUEUE_DEPTH + 2); // holds QUEUE_DEPTH+1
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);
    localparam logic [31:0] RESET_PC = 32'hbfc0_0000;    // boot vector

    // primary opcode field
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // funct field of SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef logic [31:0]         word_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [CREDIT_W-1:0] credit_cnt_t;
    typedef logic [PTR_W-1:0]    q_ptr_t;

    typedef enum logic [3:0] {
        OP_NOP, // unknown encodings land here
        OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT,
        OP_ADDIU, OP_ORI, OP_LUI,
        OP_BEQ, OP_BNE, OP_J
    } op_e;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_entry_t;

    typedef struct packed {
        credit_cnt_t count; // slots freed at the previous edge
    } credit_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        op_e       op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dst;
        word_t     imm;         // already extended
        word_t     jump_target; // branch or jump destination
    } decoded_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      rf_wen;
        reg_addr_t rf_wnum;
        word_t     rf_wdata;
    } retire_trace_t;

endpackage

// ==== design/fetch_unit.sv ====
/*
 * Instruction fetch. Keeps the PC and a credit count of free queue slots,
 * and pushes one {pc, instr} pair per cycle while credit remains.
 * A redirect from execute reloads the PC.
 */

`timescale 1ns/1ps

module fetch_unit (
    input  logic                   aclk,
    input  logic                   rst_n,
    output cpu_pkg::word_t         imem_addr,
    input  cpu_pkg::word_t         imem_data,
    input  cpu_pkg::credit_t       credit,
    input  cpu_pkg::redirect_t     redirect,
    output logic                   push_valid,
    output cpu_pkg::fetch_entry_t  push_entry
);

    cpu_pkg::word_t       pc;
    cpu_pkg::credit_cnt_t credits;

    assign imem_addr  = pc;
    assign push_valid = (credits != '0); // queue drops it if a redirect hits this cycle

    always_comb begin
        push_entry.pc    = pc;
        push_entry.instr = imem_data; // memory answers in the same cycle
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= cpu_pkg::RESET_PC;
            credits <= cpu_pkg::credit_cnt_t'(cpu_pkg::QUEUE_DEPTH);
        end else begin
            if (redirect.valid) begin
                pc <= redirect.target;
            end else if (push_valid) begin
                pc <= pc + 32'd4;
            end
            // a dropped push still spends a credit, the queue hands it back
            credits <= credits - cpu_pkg::credit_cnt_t'(push_valid) + credit.count;
        end
    end

endmodule

// ==== design/instr_queue.sv ====
/*
 * Circular instruction FIFO between fetch and execute.
 * A redirect empties it at the edge, dropping any push from that cycle.
 * Freed slots are returned to fetch one cycle later as credit.
 */

`timescale 1ns/1ps

module instr_queue (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   push_valid,
    input  cpu_pkg::fetch_entry_t  push_entry,
    input  logic                   pop,
    input  cpu_pkg::redirect_t     redirect,
    output logic                   head_valid,
    output cpu_pkg::fetch_entry_t  head,
    output cpu_pkg::credit_t       credit
);

    cpu_pkg::fetch_entry_t mem [cpu_pkg::QUEUE_DEPTH];
    cpu_pkg::q_ptr_t       wr_ptr;
    cpu_pkg::q_ptr_t       rd_ptr;
    cpu_pkg::credit_cnt_t  count;
    logic                  push_ok;
    logic                  pop_ok;

    assign push_ok    = push_valid && !redirect.valid;
    assign pop_ok     = pop && head_valid;
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= '0;
        end else if (redirect.valid) begin
            // flush returns everything held plus the dropped push
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credit.count <= count + cpu_pkg::credit_cnt_t'(push_valid);
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + cpu_pkg::q_ptr_t'(1); // wraps since depth is a power of two
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + cpu_pkg::q_ptr_t'(1);
            end
            count <= count + cpu_pkg::credit_cnt_t'(push_ok)
                           - cpu_pkg::credit_cnt_t'(pop_ok);
            credit.count <= cpu_pkg::credit_cnt_t'(pop_ok);
        end
    end

endmodule

// ==== design/instr_decoder.sv ====
/*
 * Combinational decoder for the supported MIPS subset.
 * Produces the operation, register numbers, extended immediate and
 * the branch or jump target from the instruction word and its pc.
 */

`timescale 1ns/1ps

module instr_decoder (
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::word_t    pc,
    output cpu_pkg::decoded_t dec
);

    logic [5:0]     opcode;
    logic [5:0]     funct;
    cpu_pkg::word_t simm;
    cpu_pkg::word_t zimm;
    cpu_pkg::word_t pc_plus4;

    assign opcode   = instr[31:26];
    assign funct    = instr[5:0];
    assign simm     = {{16{instr[15]}}, instr[15:0]};
    assign zimm     = {16'h0000, instr[15:0]};
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        dec.op          = cpu_pkg::OP_NOP;
        dec.rs          = instr[25:21];
        dec.rt          = instr[20:16];
        dec.dst         = instr[20:16];                   // rt for I-type
        dec.imm         = simm;
        dec.jump_target = pc_plus4 + {simm[29:0], 2'b00}; // branch target

        case (opcode)
            cpu_pkg::OPC_SPECIAL: begin
                dec.dst = instr[15:11];
                case (funct)
                    cpu_pkg::FN_ADDU: dec.op = cpu_pkg::OP_ADDU;
                    cpu_pkg::FN_SUBU: dec.op = cpu_pkg::OP_SUBU;
                    cpu_pkg::FN_AND:  dec.op = cpu_pkg::OP_AND;
                    cpu_pkg::FN_OR:   dec.op = cpu_pkg::OP_OR;
                    cpu_pkg::FN_XOR:  dec.op = cpu_pkg::OP_XOR;
                    cpu_pkg::FN_SLT:  dec.op = cpu_pkg::OP_SLT;
                    default:          dec.op = cpu_pkg::OP_NOP;
                endcase
            end
            cpu_pkg::OPC_J: begin
                dec.op          = cpu_pkg::OP_J;
                dec.jump_target = {pc_plus4[31:28], instr[25:0], 2'b00};
            end
            cpu_pkg::OPC_BEQ:   dec.op = cpu_pkg::OP_BEQ;
            cpu_pkg::OPC_BNE:   dec.op = cpu_pkg::OP_BNE;
            cpu_pkg::OPC_ADDIU: dec.op = cpu_pkg::OP_ADDIU;
            cpu_pkg::OPC_ORI: begin
                dec.op  = cpu_pkg::OP_ORI;
                dec.imm = zimm;
            end
            cpu_pkg::OPC_LUI: begin
                dec.op  = cpu_pkg::OP_LUI;
                dec.imm = zimm; // shifted up in the ALU
            end
            default: dec.op = cpu_pkg::OP_NOP;
        endcase
    end

endmodule

// ==== design/reg_file.sv ====
/*
 * 32 x 32 register file, two async read ports and one write port.
 * Register 0 always reads zero.
 */

`timescale 1ns/1ps

module reg_file (
    input  logic               aclk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs,
    input  cpu_pkg::reg_addr_t rt,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    input  logic               wen,
    input  cpu_pkg::reg_addr_t wnum,
    input  cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t regs [32];

    assign rs_data = (rs == '0) ? '0 : regs[rs];
    assign rt_data = (rt == '0) ? '0 : regs[rt];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wnum != '0)) begin
            regs[wnum] <= wdata;
        end
    end

endmodule

// ==== design/execute_unit.sv ====
/*
 * Execute and writeback. Pops the queue head when the trace is ready,
 * runs the ALU or resolves the branch, writes the register file and
 * registers one retire record per popped instruction.
 */

`timescale 1ns/1ps

module execute_unit (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   head_valid,
    input  cpu_pkg::fetch_entry_t  head,
    input  logic                   trace_ready,
    output logic                   pop,
    output cpu_pkg::redirect_t     redirect,
    output cpu_pkg::retire_trace_t trace
);

    cpu_pkg::decoded_t dec;
    cpu_pkg::word_t    rs_data;
    cpu_pkg::word_t    rt_data;
    cpu_pkg::word_t    alu_result;
    logic              alu_wr;  // op writes a register
    logic              taken;
    logic              rf_wen;

    instr_decoder u_decoder (
        .instr (head.instr),
        .pc    (head.pc),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .rs      (dec.rs),
        .rt      (dec.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wen     (rf_wen),
        .wnum    (dec.dst),
        .wdata   (alu_result)
    );

    assign pop = head_valid && trace_ready;

    always_comb begin
        alu_result = '0;
        alu_wr     = 1'b0;
        taken      = 1'b0;
        case (dec.op)
            cpu_pkg::OP_ADDU:  begin alu_result = rs_data + rt_data;  alu_wr = 1'b1; end
            cpu_pkg::OP_SUBU:  begin alu_result = rs_data - rt_data;  alu_wr = 1'b1; end
            cpu_pkg::OP_AND:   begin alu_result = rs_data & rt_data;  alu_wr = 1'b1; end
            cpu_pkg::OP_OR:    begin alu_result = rs_data | rt_data;  alu_wr = 1'b1; end
            cpu_pkg::OP_XOR:   begin alu_result = rs_data ^ rt_data;  alu_wr = 1'b1; end
            cpu_pkg::OP_SLT: begin
                alu_result = {31'd0, $signed(rs_data) < $signed(rt_data)};
                alu_wr     = 1'b1;
            end
            cpu_pkg::OP_ADDIU: begin alu_result = rs_data + dec.imm;  alu_wr = 1'b1; end
            cpu_pkg::OP_ORI:   begin alu_result = rs_data | dec.imm;  alu_wr = 1'b1; end
            cpu_pkg::OP_LUI: begin
                alu_result = {dec.imm[15:0], 16'h0000};
                alu_wr     = 1'b1;
            end
            cpu_pkg::OP_BEQ:   taken = (rs_data == rt_data);
            cpu_pkg::OP_BNE:   taken = (rs_data != rt_data);
            cpu_pkg::OP_J:     taken = 1'b1;
            default:           taken = 1'b0; // unknown, retires as a no-op
        endcase
    end

    assign rf_wen = pop && alu_wr && (dec.dst != '0);

    // no delay slot, so the redirect flushes everything behind it
    assign redirect.valid  = pop && taken;
    assign redirect.target = dec.jump_target;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            trace <= '0;
        end else begin
            trace.valid <= pop;
            if (pop) begin
                trace.pc       <= head.pc;
                trace.rf_wen   <= rf_wen;
                trace.rf_wnum  <= dec.dst;
                trace.rf_wdata <= alu_result;
            end
        end
    end

endmodule

// ==== design/mycpu_top.sv ====
/*
 * Core top level. Ties fetch, the instruction queue and execute together.
 * Instruction memory is external and answers imem_addr in the same cycle.
 */

`timescale 1ns/1ps

module mycpu_top (
    input  logic                   aclk,
    input  logic                   rst_n,
    output cpu_pkg::word_t         imem_addr,
    input  cpu_pkg::word_t         imem_data,
    input  logic                   trace_ready,
    output cpu_pkg::retire_trace_t trace
);

    logic                  push_valid;
    cpu_pkg::fetch_entry_t push_entry;
    cpu_pkg::credit_t      credit;     // queue back to fetch
    logic                  head_valid;
    cpu_pkg::fetch_entry_t head;
    logic                  pop;
    cpu_pkg::redirect_t    redirect;   // to fetch and queue

    fetch_unit u_fetch (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .credit     (credit),
        .redirect   (redirect),
        .push_valid (push_valid),
        .push_entry (push_entry)
    );

    instr_queue u_queue (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .push_valid (push_valid),
        .push_entry (push_entry),
        .pop        (pop),
        .redirect   (redirect),
        .head_valid (head_valid),
        .head       (head),
        .credit     (credit)
    );

    execute_unit u_execute (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .head_valid  (head_valid),
        .head        (head),
        .trace_ready (trace_ready),
        .pop         (pop),
        .redirect    (redirect),
        .trace       (trace)
    );

endmodule

// ==== dv/tb_mycpu_top.sv ====
/*
 * Directed testbench for the MIPS-subset core.
 * Models instruction memory, runs each program on an instruction-set model
 * and scores every retire beat against it. Built and run by run.sh.
 */

`timescale 1ns/1ps

module tb_mycpu_top;

    localparam int MAX_WORDS = 256;
    localparam int SPAN      = 4 * (cpu_pkg::QUEUE_DEPTH + 1); // fetch lead allowed in a stall

    logic                   aclk;
    logic                   rst_n;
    cpu_pkg::word_t         imem_addr;
    cpu_pkg::word_t         imem_data;
    logic                   trace_ready;
    cpu_pkg::retire_trace_t trace;

    cpu_pkg::word_t         prog [MAX_WORDS];
    int                     prog_len;
    cpu_pkg::retire_trace_t expected [$]; // retire list from the model
    int                     sb_idx;       // next expected entry
    int                     value_errs;
    int                     other_errs;
    logic                   stall_check;
    logic                   last_valid;   // trace.valid at the last falling edge
    logic [31:0]            rng;

    mycpu_top dut (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .trace_ready (trace_ready),
        .trace       (trace)
    );

    always #10 aclk = ~aclk;

    function automatic cpu_pkg::word_t imem_read(cpu_pkg::word_t addr);
        cpu_pkg::word_t offs;
        offs = addr - cpu_pkg::RESET_PC;
        if (offs < 32'(4 * prog_len)) begin
            return prog[offs[9:2]];
        end
        return {6'h3f, addr[25:0] ^ {20'd0, addr[31:26]}}; // unknown opcode retires as a no-op
    endfunction

    always_comb imem_data = imem_read(imem_addr);

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cpu_pkg::word_t r_format(logic [5:0] fn, int rd, int rs, int rt);
        return {cpu_pkg::OPC_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    // operands in assembler order with rt first
    function automatic cpu_pkg::word_t i_format(logic [5:0] opc, int rt, int rs, logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic cpu_pkg::word_t jump_to(int word_idx);
        cpu_pkg::word_t target;
        target = cpu_pkg::RESET_PC + 32'(4 * word_idx);
        return {cpu_pkg::OPC_J, target[27:2]};
    endfunction

    task automatic emit(cpu_pkg::word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_reg(string name, cpu_pkg::reg_addr_t got, cpu_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    // instruction-set model from the boot address until it leaves the program
    task automatic build_expected();
        cpu_pkg::word_t         regs [32];
        cpu_pkg::word_t         pc;
        cpu_pkg::word_t         ins;
        cpu_pkg::word_t         a;
        cpu_pkg::word_t         b;
        cpu_pkg::word_t         sext;
        cpu_pkg::word_t         result;
        cpu_pkg::word_t         next_pc;
        cpu_pkg::reg_addr_t     dst;
        cpu_pkg::retire_trace_t e;
        logic                   writes;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        expected.delete();
        pc = cpu_pkg::RESET_PC;
        while ((pc - cpu_pkg::RESET_PC) < 32'(4 * prog_len) && expected.size() < 400) begin
            ins     = imem_read(pc);
            a       = regs[ins[25:21]];
            b       = regs[ins[20:16]];
            sext    = {{16{ins[15]}}, ins[15:0]};
            next_pc = pc + 32'd4;
            writes  = 1'b1;
            dst     = ins[20:16];
            result  = '0;
            if (ins[31:26] == cpu_pkg::OPC_SPECIAL) begin
                dst = ins[15:11];
                case (ins[5:0])
                    cpu_pkg::FN_ADDU: result = a + b;
                    cpu_pkg::FN_SUBU: result = a - b;
                    cpu_pkg::FN_AND:  result = a & b;
                    cpu_pkg::FN_OR:   result = a | b;
                    cpu_pkg::FN_XOR:  result = a ^ b;
                    cpu_pkg::FN_SLT:  result = {31'd0, $signed(a) < $signed(b)};
                    default:          writes = 1'b0;
                endcase
            end else begin
                case (ins[31:26])
                    cpu_pkg::OPC_ADDIU: result = a + sext;
                    cpu_pkg::OPC_ORI:   result = a | {16'h0000, ins[15:0]};
                    cpu_pkg::OPC_LUI:   result = {ins[15:0], 16'h0000};
                    cpu_pkg::OPC_BEQ: begin
                        writes = 1'b0;
                        if (a == b) begin
                            next_pc = pc + 32'd4 + (sext << 2);
                        end
                    end
                    cpu_pkg::OPC_BNE: begin
                        writes = 1'b0;
                        if (a != b) begin
                            next_pc = pc + 32'd4 + (sext << 2);
                        end
                    end
                    cpu_pkg::OPC_J: begin
                        writes  = 1'b0;
                        next_pc = {next_pc[31:28], ins[25:0], 2'b00};
                    end
                    default: writes = 1'b0;
                endcase
            end
            e.valid    = 1'b1;
            e.pc       = pc;
            e.rf_wen   = writes && (dst != '0);
            e.rf_wnum  = dst;
            e.rf_wdata = result;
            if (e.rf_wen) begin
                regs[dst] = result;
            end
            expected.push_back(e);
            pc = next_pc;
        end
    endtask

    // scoreboard sampled at the falling edge where the trace is stable
    task automatic score_trace();
        cpu_pkg::retire_trace_t e;
        cpu_pkg::word_t         lead;
        if (!rst_n) begin
            return;
        end
        last_valid = trace.valid;
        if (stall_check && trace.valid) begin
            $display("retire seen at pc %h while trace_ready was low", trace.pc);
            other_errs++;
        end
        if (trace.valid) begin
            if (sb_idx < expected.size()) begin
                e = expected[sb_idx];
                check_word("trace.pc", trace.pc, e.pc);
                check_flag("trace.rf_wen", trace.rf_wen, e.rf_wen);
                if (e.rf_wen) begin
                    check_reg("trace.rf_wnum", trace.rf_wnum, e.rf_wnum);
                    check_word("trace.rf_wdata", trace.rf_wdata, e.rf_wdata);
                end
                sb_idx++;
            end else if ((trace.pc - cpu_pkg::RESET_PC) < 32'(4 * prog_len)) begin
                $display("extra retire at pc %h after the expected sequence", trace.pc);
                other_errs++;
            end
        end
        if (stall_check && sb_idx < expected.size()) begin
            lead = imem_addr - expected[sb_idx].pc;
            if (lead > 32'(SPAN)) begin
                $display("ERR imem_addr: got %h, next unretired pc %h", imem_addr,
                         expected[sb_idx].pc);
                value_errs++;
            end
        end
    endtask

    task automatic cycle();
        @(negedge aclk);
        score_trace();
        @(posedge aclk);
    endtask

    task automatic begin_test();
        cycle();
        rst_n       <= 1'b0;
        trace_ready <= 1'b0;
        cycle();
        prog_len    = 0;
        sb_idx      = 0;
        stall_check = 1'b0;
    endtask

    task automatic release_reset();
        build_expected();
        repeat (15) cycle(); // 16 low cycles counting the one in begin_test
        rst_n       <= 1'b1;
        trace_ready <= 1'b1;
    endtask

    // straight-line code, first retire in the third cycle after release, then one per cycle
    task automatic check_retire_cadence(int count);
        for (int i = 0; i < count + 2; i++) begin
            cycle();
            check_flag("trace.valid", last_valid, i >= 2);
        end
    endtask

    task automatic wait_retired(int count, int limit, logic random_ready);
        int n;
        n = 0;
        while (sb_idx < count && n < limit) begin
            cycle();
            if (random_ready) begin
                rng = xorshift(rng);
                trace_ready <= rng[0] | rng[1];
            end
            n++;
        end
        if (sb_idx < count) begin
            $display("timeout after %0d cycles, %0d of %0d instructions retired",
                     limit, sb_idx, count);
            other_errs++;
        end
        trace_ready <= 1'b1;
    endtask

    task automatic alu_register_ops();
        begin_test();
        emit(i_format(cpu_pkg::OPC_ADDIU, 1, 0, 16'h0005));
        emit(i_format(cpu_pkg::OPC_ADDIU, 2, 0, 16'hfffd)); // -3
        emit(r_format(cpu_pkg::FN_ADDU, 3, 1, 2));
        emit(r_format(cpu_pkg::FN_SUBU, 4, 1, 2));
        emit(r_format(cpu_pkg::FN_AND, 5, 1, 2));
        emit(r_format(cpu_pkg::FN_OR, 6, 1, 2));
        emit(r_format(cpu_pkg::FN_XOR, 7, 1, 2));
        emit(r_format(cpu_pkg::FN_SLT, 8, 2, 1));
        emit(r_format(cpu_pkg::FN_SLT, 9, 1, 2));
        emit(r_format(cpu_pkg::FN_SUBU, 10, 2, 1));
        emit(r_format(cpu_pkg::FN_SLT, 11, 10, 2));  // both negative
        release_reset();
        check_retire_cadence(expected.size());
        wait_retired(expected.size(), 200, 1'b0);
    endtask

    task automatic immediates_and_zero();
        begin_test();
        emit(i_format(cpu_pkg::OPC_LUI, 1, 0, 16'h1234));
        emit(i_format(cpu_pkg::OPC_ORI, 1, 1, 16'h5678));
        emit(i_format(cpu_pkg::OPC_ADDIU, 2, 0, 16'hffff));
        emit(i_format(cpu_pkg::OPC_ADDIU, 3, 1, 16'h8000));
        emit(i_format(cpu_pkg::OPC_ORI, 4, 0, 16'hffff)); // zero extended
        emit(i_format(cpu_pkg::OPC_ADDIU, 0, 1, 16'h0007));
        emit(i_format(cpu_pkg::OPC_LUI, 0, 0, 16'hdead));
        emit(r_format(cpu_pkg::FN_ADDU, 0, 1, 1));
        emit(r_format(cpu_pkg::FN_ADDU, 5, 0, 0));
        emit(r_format(cpu_pkg::FN_OR, 6, 0, 1));
        emit(i_format(cpu_pkg::OPC_ADDIU, 7, 0, 16'h0001));
        release_reset();
        check_retire_cadence(expected.size());
        wait_retired(expected.size(), 200, 1'b0);
    endtask

    task automatic branches_and_jump();
        begin_test();
        emit(i_format(cpu_pkg::OPC_ADDIU, 1, 0, 16'h0001));
        emit(i_format(cpu_pkg::OPC_ADDIU, 2, 0, 16'h0001));
        emit(i_format(cpu_pkg::OPC_BEQ, 2, 1, 16'h0002));   // taken to word 5
        emit(i_format(cpu_pkg::OPC_ADDIU, 9, 0, 16'h0bad));
        emit(i_format(cpu_pkg::OPC_ADDIU, 9, 0, 16'h0bae));
        emit(i_format(cpu_pkg::OPC_BNE, 2, 1, 16'h0001));   // not taken
        emit(i_format(cpu_pkg::OPC_ADDIU, 3, 0, 16'h0006));
        emit(i_format(cpu_pkg::OPC_BNE, 3, 1, 16'h0002));   // taken to word 10
        emit(i_format(cpu_pkg::OPC_ADDIU, 9, 0, 16'h0baf));
        emit(i_format(cpu_pkg::OPC_ADDIU, 9, 0, 16'h0bb0));
        emit(i_format(cpu_pkg::OPC_BEQ, 3, 1, 16'h0001));   // not taken
        emit(i_format(cpu_pkg::OPC_ADDIU, 4, 0, 16'h000b));
        emit(jump_to(15));
        emit(i_format(cpu_pkg::OPC_ADDIU, 9, 0, 16'h0bb1));
        emit(i_format(cpu_pkg::OPC_ADDIU, 9, 0, 16'h0bb2));
        emit(i_format(cpu_pkg::OPC_ADDIU, 5, 0, 16'h000f));
        emit(r_format(cpu_pkg::FN_ADDU, 6, 4, 5));
        release_reset();
        wait_retired(expected.size(), 200, 1'b0);
    endtask

    task automatic back_pressure();
        begin_test();
        for (int i = 0; i < 12; i++) begin
            emit(i_format(cpu_pkg::OPC_ADDIU, 1, 1, 16'(i + 1)));
            emit(r_format(cpu_pkg::FN_ADDU, 2, 2, 1));
        end
        release_reset();
        wait_retired(6, 100, 1'b0);
        trace_ready <= 1'b0;
        cycle();              // the pop at this edge still retires
        stall_check = 1'b1;
        repeat (29) cycle();
        stall_check = 1'b0;
        trace_ready <= 1'b1;
        wait_retired(expected.size(), 200, 1'b0);
    endtask

    task automatic random_programs();
        logic [5:0] fns [6] = '{cpu_pkg::FN_ADDU, cpu_pkg::FN_SUBU, cpu_pkg::FN_AND,
                                cpu_pkg::FN_OR, cpu_pkg::FN_XOR, cpu_pkg::FN_SLT};
        logic [5:0] opcs [3] = '{cpu_pkg::OPC_ADDIU, cpu_pkg::OPC_ORI, cpu_pkg::OPC_LUI};
        int         kind;
        begin_test();
        for (int i = 0; i < 40; i++) begin
            rng  = xorshift(rng);
            kind = int'(rng[31:28]) % 9;
            if (kind < 6) begin
                emit(r_format(fns[kind], int'(rng[2:0]), int'(rng[5:3]), int'(rng[8:6])));
            end else begin
                emit(i_format(opcs[kind - 6], int'(rng[2:0]), int'(rng[5:3]), rng[24:9]));
            end
        end
        release_reset();
        wait_retired(expected.size(), 400, 1'b1);
    endtask

    initial begin
        aclk        = 1'b0;
        rst_n       <= 1'b0;
        trace_ready <= 1'b0;
        prog_len    = 0;
        sb_idx      = 0;
        value_errs  = 0;
        other_errs  = 0;
        stall_check = 1'b0;
        last_valid  = 1'b0;
        rng         = 32'hcd69;
        alu_register_ops();
        immediates_and_zero();
        branches_and_jump();
        back_pressure();
        random_programs();
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== mycpu_top.f ====
design/cpu_pkg.sv
design/fetch_unit.sv
design/instr_queue.sv
design/instr_decoder.sv
design/reg_file.sv
design/execute_unit.sv
design/mycpu_top.sv
dv/tb_mycpu_top.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_mycpu_top -f mycpu_top.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qF "ALL CHECKS PASSED" ||
{ echo "simulation failed"; exit 1; }
